//--- compile.f
+incdir+include
source/nib_pkg.sv
source/nib_alu.sv
source/nib_regfile.sv
source/nib_control.sv
source/nib_cpu.sv
dv/nib_cpu_sva.sv
dv/nib_tb.sv

//--- run.sh
#!/bin/sh
# Builds the nibble CPU testbench with Verilator and runs it.
# The run passes only if the simulation prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module nib_tb -o nib_sim \
	&& ./obj_dir/nib_sim | tee /dev/stderr | grep "^Test completed successfully$" > /dev/null \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }

//--- dv/nib_tb.sv
// Self-checking testbench for the nibble CPU.
// Builds a random program below 0x400 and keeps all stored data at 0x400 and up.
// R4, R5 and R6 are written only by MOV immediate, so jump targets are known when built.
// The program ends in a self-jump and the run stops once PC reaches it.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_tb;

	import nib_pkg::*;

	localparam int MEM_SIZE = 1 << `NIB_ADDR_W;
	localparam int GROUPS   = 40;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic [`NIB_ADDR_W-1:0] bus_addr;
	logic                   bus_we;
	logic [`NIB_DATA_W-1:0] bus_wdata;
	logic [`NIB_DATA_W-1:0] bus_rdata;

	logic [`NIB_DATA_W-1:0] mem   [MEM_SIZE];
	logic [`NIB_DATA_W-1:0] image [MEM_SIZE];  // Program and fill as loaded
	string tag_of [int];                       // Test name per STO address
	int    exp_addr_q [$];
	int    exp_data_q [$];
	string exp_tag_q  [$];

	integer seed = 32'hf30a;
	int gen_pc;
	int instr_count;
	int halt_pc;
	int exp_total;
	int limit_ns = 0;
	int writes_seen = 0;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;

	always #5 clk = ~clk;

	nib_cpu nib_cpu_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus_rdata_i (bus_rdata),
		.bus_addr_o  (bus_addr),
		.bus_we_o    (bus_we),
		.bus_wdata_o (bus_wdata)
	);

	assign bus_rdata = mem[bus_addr];  // Same-cycle read

	always @(posedge clk) begin
		if (bus_we) begin
			mem[bus_addr] <= bus_wdata;
		end
	end

	function automatic int pick(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic int free_reg();  // Any register but R4..R6
		int d;
		d = pick(5);
		return (d == 4) ? 7 : d;
	endfunction

	task automatic write_nibble(input int v);
		image[gen_pc] = v[3:0];
		gen_pc++;
	endtask

	task automatic put_instr(input int op, input int opt, input int a1, input int a2);
		write_nibble(op);
		write_nibble(opt * 4 + a1 / 2);
		write_nibble((a1 % 2) * 8 + a2);
		instr_count++;
	endtask

	task automatic mov_imm(input int rd, input int v);
		put_instr(`NIB_OP_MOV, 1, 0, rd);
		write_nibble(v);
	endtask

	task automatic point_at(input int addr);  // 12 nibbles
		mov_imm(`NIB_REG_ADR0, addr % 16);
		mov_imm(`NIB_REG_ADR1, (addr / 16) % 16);
		mov_imm(`NIB_REG_ADR2, addr / 256);
	endtask

	task automatic store_reg(input int rs, input string tag);
		tag_of[gen_pc] = tag;
		put_instr(`NIB_OP_STO, 0, 0, rs);
	endtask

	task automatic add_group(input int kind);
		int a;
		int b;
		int k;
		string name;
		a = free_reg();
		b = pick(8);
		k = pick(7);
		case (kind)
			0: begin
				mov_imm(a, pick(16));
				put_instr(`NIB_OP_MOV, 0, a, b % 4);  // R[b] gets R[a]
				point_at(1024 + pick(1024));
				store_reg(b % 4, "mov_reg");
				store_reg(a, "mov_imm");
			end
			1: begin
				mov_imm(a, pick(16));
				if (b < 4 || b > 6) begin
					mov_imm(b, pick(16));
				end
				case (k)
					0: begin name = "add"; put_instr(`NIB_OP_ADD, 0, a, b); end
					1: begin name = "sub"; put_instr(`NIB_OP_SUB, 0, a, b); end
					2: begin name = "and"; put_instr(`NIB_OP_ANDOR, 0, a, b); end
					3: begin name = "or"; put_instr(`NIB_OP_ANDOR, 2, a, b); end
					4: begin name = "xor"; put_instr(`NIB_OP_XOR, 0, a, b); end
					5: begin name = "shl"; put_instr(`NIB_OP_SHLR, 0, 0, a); end
					default: begin name = "shr"; put_instr(`NIB_OP_SHLR, 1, 0, a); end
				endcase
				if (a == `NIB_REG_FLAGS) begin
					name = {name, "_into_r3"};
				end
				point_at(1024 + pick(1024));
				store_reg(a, name);
				store_reg(`NIB_REG_FLAGS, {name, "_flags"});
			end
			2: begin
				point_at(1024 + pick(1024));
				put_instr(`NIB_OP_LD, 0, 0, a);
				point_at(1024 + pick(1024));
				store_reg(a, "ld_sto");
			end
			3: begin
				// Flags from XOR for JNZ, ADD for JNC, SUB for JNB
				k = pick(4);
				b = pick(16);
				mov_imm(0, b);
				mov_imm(1, pick(2) ? b : pick(16));
				put_instr((k == 3) ? `NIB_OP_SUB : ((k == 2) ? `NIB_OP_ADD : `NIB_OP_XOR), 0, 0, 1);
				point_at(gen_pc + 22);  // Past setup, jump and the skipped block
				case (k)
					0: begin name = "jmp"; put_instr(`NIB_OP_JMP, 0, 0, 0); end
					1: begin name = "jnz"; put_instr(`NIB_OP_JNZ, 0, 0, 0); end
					2: begin name = "jnc"; put_instr(`NIB_OP_JNC, 0, 0, 0); end
					default: begin name = "jnb"; put_instr(`NIB_OP_JNC, 2, 0, 0); end
				endcase
				mov_imm(`NIB_REG_ADR2, 4 + pick(4));
				store_reg(0, {name, "_not_taken"});
			end
			default: put_instr((b % 5 < 3) ? 4 + 2 * (b % 5) : 11 + b % 5, pick(4), pick(8), k);
		endcase
	endtask

	// Runs the image by the ISA rules and queues every store in order
	function automatic int run_reference();
		logic [3:0] m [MEM_SIZE];
		int r [8];
		int pc, start, op, opt, a1, a2, addr, x, y, res, stores;
		bit taken, halted, alu_op;
		flags_u f;
		flags_u cur;
		for (int i = 0; i < MEM_SIZE; i++) m[i] = image[i];
		for (int i = 0; i < 8; i++) r[i] = 0;
		pc = 0;
		stores = 0;
		halted = 0;
		for (int step = 0; step < 20000 && !halted; step++) begin
			start = pc;
			op = m[pc];
			opt = m[pc + 1] / 4;
			a1 = (m[pc + 1] % 4) * 2 + m[pc + 2] / 8;
			a2 = m[pc + 2] % 8;
			pc = (pc + 3) % MEM_SIZE;
			addr = (r[6] % 8) * 256 + r[5] * 16 + r[4];
			x = r[a1];
			y = r[a2];
			cur.raw = 4'(r[3]);
			f.raw = 4'h0;
			res = 0;
			taken = 0;
			alu_op = 1;
			case (op)
				3: begin res = (x + y) % 16; f.bits.carry = (x + y > 15); end
				5: begin res = (x - y + 16) % 16; f.bits.borrow = (x < y); end
				9: res = (opt >= 2) ? (x | y) : (x & y);
				10: res = x ^ y;
				7: begin
					res = (opt == 1) ? y / 2 : (y * 2) % 16;
					f.bits.carry = (opt == 1) ? y % 2 : y / 8;
				end
				default: alu_op = 0;
			endcase
			case (op)
				0: begin
					if (opt == 1) begin
						r[a2] = m[pc];
						pc = (pc + 1) % MEM_SIZE;
					end else begin
						r[a2] = x;
					end
				end
				1: begin
					exp_addr_q.push_back(addr);
					exp_data_q.push_back(y);
					exp_tag_q.push_back(tag_of.exists(start) ? tag_of[start] : "store");
					m[addr] = 4'(y);
					stores++;
				end
				2: r[a2] = m[addr];
				11: taken = 1;
				12: taken = !cur.bits.zero;
				13: taken = (opt >= 2) ? !cur.bits.borrow : !cur.bits.carry;
				default: ;
			endcase
			if (alu_op) begin
				f.bits.zero = (res == 0);
				r[(op == 7) ? a2 : a1] = res;
				r[3] = f.raw;  // Flags land last
			end
			if (taken) begin
				halted = (addr == start);
				pc = addr;
			end
		end
		return stores;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			mismatches++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	always @(negedge clk) begin
		string tag;
		if (!rst_n && bus_we) begin
			writes_seen++;
			if (exp_addr_q.size() == 0) begin
				other_errors++;
				$display("ERROR: bus write to %h after the last expected store", bus_addr);
			end else begin
				tag = exp_tag_q.pop_front();
				check_value({tag, " address"}, exp_addr_q.pop_front(), bus_addr);
				check_value({tag, " data"}, exp_data_q.pop_front(), bus_wdata);
			end
		end
	end

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		other_errors++;
		$display("ERROR: timeout, the CPU did not reach its halt loop in %0d ns", limit_ns);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors", checks, mismatches,
			other_errors);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b1;
		for (int a = 0; a < MEM_SIZE; a++) begin
			image[a] = 4'((a ^ (a >> 4) ^ (a >> 8) ^ 5) & 15);
		end
		gen_pc = 0;
		instr_count = 0;
		for (int g = 0; g < GROUPS; g++) begin
			add_group(g % 5);
		end
		halt_pc = gen_pc + 12;
		point_at(halt_pc);
		put_instr(`NIB_OP_JMP, 0, 0, 0);
		for (int a = 0; a < MEM_SIZE; a++) begin
			mem[a] <= image[a];
		end
		exp_total = run_reference();
		limit_ns = instr_count * 5 * 10 + 2000;  // Reset and final wait in the margin
		repeat (10) @(negedge clk);
		rst_n = 1'b0;
		while (bus_addr !== halt_pc[`NIB_ADDR_W-1:0]) @(negedge clk);
		repeat (12) @(negedge clk);  // A few turns of the halt loop
		check_value("write count", exp_total, writes_seen);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors", checks, mismatches,
			other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- dv/nib_cpu_sva.sv
// Concurrent checks on the nibble CPU controller, bound into nib_control.
// State code 4 is the execute state. rst_n is active high.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_cpu_sva (
	input logic                   clk,
	input logic                   rst_n,
	input logic [2:0]             state_i,
	input logic [`NIB_ADDR_W-1:0] pc_i,
	input logic [3:0]             opcode_i,
	input logic                   bus_we_i
);

	localparam logic [2:0] EXEC = 3'd4;

	logic is_jump;

	assign is_jump = (opcode_i == `NIB_OP_JMP) || (opcode_i == `NIB_OP_JNZ) ||
		(opcode_i == `NIB_OP_JNC);

	we_only_in_exec: assert property (@(posedge clk) disable iff (rst_n)
		(state_i != EXEC) |-> !bus_we_i)
		else $error("bus write enable high outside the execute state");

	we_low_after_reset: assert property (@(posedge clk) rst_n |=> !bus_we_i)
		else $error("bus write enable high right after reset");

	pc_steady: assert property (@(posedge clk) disable iff (rst_n)
		(state_i == EXEC && !is_jump) |=> (pc_i == $past(pc_i)))
		else $error("PC moved in the execute cycle of a non-jump instruction");

endmodule

bind nib_control nib_cpu_sva nib_cpu_sva_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.state_i  (state_q),
	.pc_i     (pc_q),
	.opcode_i (opcode),
	.bus_we_i (bus_we_o)
);

//--- source/nib_cpu.sv
// Nibble CPU top level: controller, register bank and ALU.
// rst_n is active high. The bus has no wait states; reads must be combinational.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_cpu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`NIB_DATA_W-1:0] bus_rdata_i,
	output logic [`NIB_ADDR_W-1:0] bus_addr_o,
	output logic                   bus_we_o,
	output logic [`NIB_DATA_W-1:0] bus_wdata_o
);

	import nib_pkg::*;

	logic [2:0]             rd_a_sel;
	logic [2:0]             rd_b_sel;
	logic [`NIB_DATA_W-1:0] rd_a;
	logic [`NIB_DATA_W-1:0] rd_b;
	logic                   wr_en;
	logic [2:0]             wr_sel;
	logic [`NIB_DATA_W-1:0] wr_data;
	logic                   flags_we;
	flags_u                 flags_d;
	flags_u                 flags;
	logic [`NIB_ADDR_W-1:0] mem_addr;
	logic [2:0]             alu_mode;
	logic [`NIB_DATA_W-1:0] alu_a;
	logic [`NIB_DATA_W-1:0] alu_b;
	logic [`NIB_DATA_W-1:0] alu_result;
	flags_u                 alu_flags;

	nib_control nib_control_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_rdata_i  (bus_rdata_i),
		.bus_addr_o   (bus_addr_o),
		.bus_we_o     (bus_we_o),
		.bus_wdata_o  (bus_wdata_o),
		.rd_a_sel_o   (rd_a_sel),
		.rd_b_sel_o   (rd_b_sel),
		.rd_a_i       (rd_a),
		.rd_b_i       (rd_b),
		.wr_en_o      (wr_en),
		.wr_sel_o     (wr_sel),
		.wr_data_o    (wr_data),
		.flags_we_o   (flags_we),
		.flags_d_o    (flags_d),
		.flags_i      (flags),
		.mem_addr_i   (mem_addr),
		.alu_mode_o   (alu_mode),
		.alu_a_o      (alu_a),
		.alu_b_o      (alu_b),
		.alu_result_i (alu_result),
		.alu_flags_i  (alu_flags)
	);

	nib_regfile nib_regfile_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_a_sel_i (rd_a_sel),
		.rd_b_sel_i (rd_b_sel),
		.rd_a_o     (rd_a),
		.rd_b_o     (rd_b),
		.wr_en_i    (wr_en),
		.wr_sel_i   (wr_sel),
		.wr_data_i  (wr_data),
		.flags_we_i (flags_we),
		.flags_d_i  (flags_d),
		.flags_o    (flags),
		.mem_addr_o (mem_addr)
	);

	nib_alu nib_alu_inst (
		.alu_mode_i (alu_mode),
		.a_i        (alu_a),
		.b_i        (alu_b),
		.result_o   (alu_result),
		.flags_o    (alu_flags)
	);

endmodule

//--- source/nib_control.sv
// Fetch and execute sequencer of the nibble CPU.
// Three fetch cycles, then one execute cycle; MOV immediate adds one fetch.
// Memory must answer reads in the same cycle; writes land on the rising edge.
// rst_n is active high and synchronous.
// Jumps go to R6[2:0]:R5:R4 and ignore the third instruction nibble.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_control (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`NIB_DATA_W-1:0] bus_rdata_i,
	output logic [`NIB_ADDR_W-1:0] bus_addr_o,
	output logic                   bus_we_o,
	output logic [`NIB_DATA_W-1:0] bus_wdata_o,
	output logic [2:0]             rd_a_sel_o,
	output logic [2:0]             rd_b_sel_o,
	input  logic [`NIB_DATA_W-1:0] rd_a_i,
	input  logic [`NIB_DATA_W-1:0] rd_b_i,
	output logic                   wr_en_o,
	output logic [2:0]             wr_sel_o,
	output logic [`NIB_DATA_W-1:0] wr_data_o,
	output logic                   flags_we_o,
	output nib_pkg::flags_u        flags_d_o,
	input  nib_pkg::flags_u        flags_i,
	input  logic [`NIB_ADDR_W-1:0] mem_addr_i,
	output logic [2:0]             alu_mode_o,
	output logic [`NIB_DATA_W-1:0] alu_a_o,
	output logic [`NIB_DATA_W-1:0] alu_b_o,
	input  logic [`NIB_DATA_W-1:0] alu_result_i,
	input  nib_pkg::flags_u        alu_flags_i
);

	localparam logic [2:0] S_FETCH0 = 3'd0;
	localparam logic [2:0] S_FETCH1 = 3'd1;
	localparam logic [2:0] S_FETCH2 = 3'd2;
	localparam logic [2:0] S_IMM    = 3'd3;
	localparam logic [2:0] S_EXEC   = 3'd4;

	logic [2:0]              state_q;
	logic [`NIB_ADDR_W-1:0]  pc_q;
	logic [`NIB_INSTR_W-1:0] instr_q;

	logic [3:0] opcode;
	logic [1:0] option;
	logic [2:0] arg1;
	logic [2:0] arg2;

	logic in_exec;
	logic is_imm;
	logic is_mem;
	logic jump_taken;

	assign opcode = instr_q[11:8];
	assign option = instr_q[7:6];
	assign arg1   = instr_q[5:3];
	assign arg2   = instr_q[2:0];

	assign in_exec = (state_q == S_EXEC);
	assign is_imm  = (opcode == `NIB_OP_MOV) && (option == 2'b01);
	assign is_mem  = (opcode == `NIB_OP_LD) || (opcode == `NIB_OP_STO);

	// Bus: PC during fetch, R6:R5:R4 for LD and STO in execute
	assign bus_addr_o  = (in_exec && is_mem) ? mem_addr_i : pc_q;
	assign bus_we_o    = in_exec && (opcode == `NIB_OP_STO);
	assign bus_wdata_o = rd_b_i;  // R[arg2]

	assign rd_a_sel_o = arg1;
	assign rd_b_sel_o = arg2;

	assign alu_a_o   = (opcode == `NIB_OP_SHLR) ? rd_b_i : rd_a_i;  // Shifts work on R[arg2]
	assign alu_b_o   = rd_b_i;
	assign flags_d_o = alu_flags_i;

	always_comb begin
		case (opcode)
			`NIB_OP_SUB:   alu_mode_o = `NIB_ALU_SUB;
			`NIB_OP_SHLR:  alu_mode_o = (option == 2'b01) ? `NIB_ALU_SHR : `NIB_ALU_SHL;
			`NIB_OP_ANDOR: alu_mode_o = option[1] ? `NIB_ALU_OR : `NIB_ALU_AND;
			`NIB_OP_XOR:   alu_mode_o = `NIB_ALU_XOR;
			default:       alu_mode_o = `NIB_ALU_ADD;
		endcase
	end

	always_comb begin
		case (opcode)
			`NIB_OP_JMP: jump_taken = 1'b1;
			`NIB_OP_JNZ: jump_taken = !flags_i.bits.zero;
			`NIB_OP_JNC: jump_taken = option[1] ? !flags_i.bits.borrow : !flags_i.bits.carry;
			default:     jump_taken = 1'b0;
		endcase
	end

	// Register write port
	always_comb begin
		wr_en_o    = 1'b0;
		wr_sel_o   = arg2;
		wr_data_o  = rd_a_i;
		flags_we_o = 1'b0;
		if (state_q == S_IMM) begin
			wr_en_o   = 1'b1;
			wr_data_o = bus_rdata_i;  // Immediate nibble
		end else if (in_exec) begin
			case (opcode)
				`NIB_OP_MOV: wr_en_o = !is_imm;  // Immediate already written
				`NIB_OP_LD: begin
					wr_en_o   = 1'b1;
					wr_data_o = bus_rdata_i;
				end
				`NIB_OP_ADD, `NIB_OP_SUB, `NIB_OP_ANDOR, `NIB_OP_XOR: begin
					wr_en_o    = 1'b1;
					wr_sel_o   = arg1;
					wr_data_o  = alu_result_i;
					flags_we_o = 1'b1;
				end
				`NIB_OP_SHLR: begin
					wr_en_o    = 1'b1;
					wr_data_o  = alu_result_i;
					flags_we_o = 1'b1;
				end
				default: wr_en_o = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q <= S_FETCH0;
			pc_q    <= '0;
			instr_q <= '0;
		end else begin
			case (state_q)
				S_FETCH0: begin
					instr_q[11:8] <= bus_rdata_i;
					pc_q          <= pc_q + 1'b1;
					state_q       <= S_FETCH1;
				end
				S_FETCH1: begin
					instr_q[7:4] <= bus_rdata_i;
					pc_q         <= pc_q + 1'b1;
					state_q      <= S_FETCH2;
				end
				S_FETCH2: begin
					instr_q[3:0] <= bus_rdata_i;
					pc_q         <= pc_q + 1'b1;
					state_q      <= is_imm ? S_IMM : S_EXEC;  // Option came in with nibble 1
				end
				S_IMM: begin
					pc_q    <= pc_q + 1'b1;
					state_q <= S_EXEC;
				end
				S_EXEC: begin
					if (jump_taken) begin
						pc_q <= mem_addr_i;
					end
					state_q <= S_FETCH0;
				end
				default: state_q <= S_FETCH0;
			endcase
		end
	end

endmodule

//--- source/nib_regfile.sv
// Eight 4-bit registers with two combinational read ports and one write port.
// rst_n is active high: all registers clear while it is 1.
// R3 doubles as the flag word; a flag write beats a data write to R3.
// mem_addr_o is R6[2:0]:R5:R4, used for LD, STO and jumps.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_regfile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [2:0]             rd_a_sel_i,
	input  logic [2:0]             rd_b_sel_i,
	output logic [`NIB_DATA_W-1:0] rd_a_o,
	output logic [`NIB_DATA_W-1:0] rd_b_o,
	input  logic                   wr_en_i,
	input  logic [2:0]             wr_sel_i,
	input  logic [`NIB_DATA_W-1:0] wr_data_i,
	input  logic                   flags_we_i,
	input  nib_pkg::flags_u        flags_d_i,
	output nib_pkg::flags_u        flags_o,
	output logic [`NIB_ADDR_W-1:0] mem_addr_o
);

	logic [`NIB_DATA_W-1:0] regs [`NIB_NREG];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < `NIB_NREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr_en_i) begin
				regs[wr_sel_i] <= wr_data_i;
			end
			if (flags_we_i) begin
				regs[`NIB_REG_FLAGS] <= flags_d_i.raw;  // Last assignment wins
			end
		end
	end

	assign rd_a_o = regs[rd_a_sel_i];
	assign rd_b_o = regs[rd_b_sel_i];

	assign flags_o.raw = regs[`NIB_REG_FLAGS];

	assign mem_addr_o = {
		regs[`NIB_REG_ADR2][`NIB_ADDR_W-2*`NIB_DATA_W-1:0],
		regs[`NIB_REG_ADR1],
		regs[`NIB_REG_ADR0]
	};

endmodule

//--- source/nib_alu.sv
// Combinational 4-bit ALU, no carry or borrow input.
// Shifts act on a_i only and fill with 0. Unnamed flag bits are 0.
`timescale 1ns/1ps
`include "nib_defs.svh"

module nib_alu (
	input  logic [2:0]             alu_mode_i,
	input  logic [`NIB_DATA_W-1:0] a_i,
	input  logic [`NIB_DATA_W-1:0] b_i,
	output logic [`NIB_DATA_W-1:0] result_o,
	output nib_pkg::flags_u        flags_o
);

	import nib_pkg::*;

	logic [`NIB_DATA_W:0]   sum;
	logic [`NIB_DATA_W-1:0] res;
	flags_u                 flg;

	assign sum = {1'b0, a_i} + {1'b0, b_i};

	always_comb begin
		res = '0;
		flg.raw = '0;
		case (alu_mode_i)
			`NIB_ALU_ADD: begin
				res = sum[`NIB_DATA_W-1:0];
				flg.bits.carry = sum[`NIB_DATA_W];
			end
			`NIB_ALU_SUB: begin
				res = a_i - b_i;
				flg.bits.borrow = (a_i < b_i);
			end
			`NIB_ALU_AND: res = a_i & b_i;
			`NIB_ALU_OR:  res = a_i | b_i;
			`NIB_ALU_XOR: res = a_i ^ b_i;
			`NIB_ALU_SHL: begin
				res = {a_i[`NIB_DATA_W-2:0], 1'b0};
				flg.bits.carry = a_i[`NIB_DATA_W-1];  // Bit shifted out
			end
			`NIB_ALU_SHR: begin
				res = {1'b0, a_i[`NIB_DATA_W-1:1]};
				flg.bits.carry = a_i[0];
			end
			default: res = '0;
		endcase
		flg.bits.zero = (res == '0);
	end

	assign result_o = res;
	assign flags_o  = flg;

endmodule

//--- source/nib_pkg.sv
// Shared types of the nibble CPU.
// R3 is both a general register and the flag word, so it is read two ways.
`include "nib_defs.svh"

package nib_pkg;

	typedef union packed {
		logic [`NIB_DATA_W-1:0] raw;
		struct packed {
			logic reserved;  // Always written as 0
			logic zero;
			logic borrow;
			logic carry;
		} bits;
	} flags_u;

endpackage

//--- include/nib_defs.svh
// Widths, register indices, opcodes and ALU mode codes of the nibble CPU.
// Opcodes 4, 6, 8, 14 and 15 have no define and execute as NOP.
`ifndef NIB_DEFS_SVH
`define NIB_DEFS_SVH

`define NIB_DATA_W     4
`define NIB_ADDR_W     11
`define NIB_INSTR_W    12  // Three nibbles
`define NIB_NREG       8

`define NIB_REG_FLAGS  3
`define NIB_REG_ADR0   4  // Address bits 3:0
`define NIB_REG_ADR1   5  // Address bits 7:4
`define NIB_REG_ADR2   6  // Only bits 2:0 reach the address

`define NIB_OP_MOV     4'd0
`define NIB_OP_STO     4'd1
`define NIB_OP_LD      4'd2
`define NIB_OP_ADD     4'd3
`define NIB_OP_SUB     4'd5
`define NIB_OP_SHLR    4'd7
`define NIB_OP_ANDOR   4'd9
`define NIB_OP_XOR     4'd10
`define NIB_OP_JMP     4'd11
`define NIB_OP_JNZ     4'd12
`define NIB_OP_JNC     4'd13  // Also JNB with option 10

`define NIB_ALU_ADD    3'd0
`define NIB_ALU_SUB    3'd1
`define NIB_ALU_AND    3'd2
`define NIB_ALU_OR     3'd3
`define NIB_ALU_XOR    3'd4
`define NIB_ALU_SHL    3'd5
`define NIB_ALU_SHR    3'd6

`endif
